//--- src/diagPkg.sv
// Diagnostic bus definitions
package diagPkg;

  ////////////////////////////////////////
  // Bus word and function code types
  ////////////////////////////////////////

  // EBUS data word, bit 0 is the most significant (PDP-10 numbering)
  typedef logic [0:35] ebusWordT;

  // Diagnostic function code as seen on the DS lines
  typedef logic [6:0] diagFuncT;

  // Phase counter within one bus write cycle
  typedef logic [2:0] diagPhaseT;

  // Step counter through the seven writes of one CRAM word
  typedef logic [2:0] cramStepT;

  // CRAM diagnostic write functions
  localparam diagFuncT diagCramAdrRh       = 7'o51;
  localparam diagFuncT diagCramAdrLh       = 7'o52;
  localparam diagFuncT diagCramWrite80To85 = 7'o53;
  localparam diagFuncT diagCramWrite60To79 = 7'o54;
  localparam diagFuncT diagCramWrite40To59 = 7'o55;
  localparam diagFuncT diagCramWrite20To39 = 7'o56;
  localparam diagFuncT diagCramWrite00To19 = 7'o57;

  // One write request for the bus driver
  typedef struct packed {
    diagFuncT func;
    ebusWordT data;
  } diagReqT;

  ////////////////////////////////////////
  // Write cycle timing
  ////////////////////////////////////////

  localparam diagPhaseT strobeCycles = 3'd3;
  localparam diagPhaseT driveCycles  = 3'd4;
  // Includes the trailing idle cycle
  localparam diagPhaseT diagCycleLen = 3'd5;

  // Nibble slots of a CRAM data write, given by the LSB of each slot
  // Slots cover EBUS bits 8-11, 14-17, 20-23, 26-29, 32-35
  localparam int nibbleSlots = 5;
  localparam int nibbleSlotLsb [nibbleSlots] = '{11, 17, 23, 29, 35};

  // Last of the seven writes per CRAM word
  localparam cramStepT cramLastStep = 3'd6;

endpackage

//--- src/loadPkg.sv
// Microcode load file definitions
package loadPkg;

  // Stream element types
  typedef logic [6:0]  asciiCharT;
  typedef logic [15:0] loadWordT;
  typedef logic [0:10] cramAdrT;
  // CRAM bits 0-85, bit 0 most significant
  typedef logic [0:85] cramWordT;

  // Character beat, fieldEnd marks a following comma
  typedef struct packed {
    asciiCharT ch;
    logic      fieldEnd;
    logic      lineEnd;
  } charBeatT;

  // Decoded field with the end of line marker carried along
  typedef struct packed {
    loadWordT value;
    logic     lineEnd;
  } wordBeatT;

  // Addressed CRAM word, or end of load marker
  typedef struct packed {
    cramAdrT  adr;
    cramWordT word;
    logic     endOfLoad;
  } cramReqT;

  // Asciized encoding
  localparam asciiCharT asciiDirectLow = 7'o075;
  localparam asciiCharT asciiOffset    = 7'o100;
  localparam int        fieldBits      = 6;

  // Load file words per CRAM location
  localparam int wordsPerCram = 6;

endpackage

//--- src/asciiDecoder.sv
// Asciized field decoder
`timescale 1ns/1ns

module asciiDecoder import loadPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  charBeatT charIn,
  input  logic     charValid,
  output logic     charReady,
  output wordBeatT wordOut,
  output logic     wordValid,
  input  logic     wordReady
);

  logic [fieldBits-1:0] digit;
  loadWordT             acc;
  loadWordT             nextAcc;
  logic                 charTake;
  logic                 fieldDone;

  // Accept a character while the output slot is free or draining
  assign charReady = !wordValid || wordReady;
  assign charTake  = charValid && charReady;
  assign fieldDone = charIn.fieldEnd || charIn.lineEnd;

  // 0100-0174 map down by the offset, 075-077 stand for themselves
  always_comb begin
    if (charIn.ch >= asciiOffset) begin
      digit = fieldBits'(charIn.ch - asciiOffset);
    end else begin
      digit = fieldBits'(charIn.ch);
    end
    // First character is the most significant digit
    nextAcc = (acc << fieldBits) | loadWordT'(digit);
  end

  // Accumulator and output valid
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acc       <= '0;
      wordValid <= 1'b0;
    end else begin
      if (charTake) begin
        acc <= fieldDone ? '0 : nextAcc;
      end
      if (charTake && fieldDone) begin
        wordValid <= 1'b1;
      end else if (wordReady) begin
        wordValid <= 1'b0;
      end
    end
  end

  // Field value register
  always_ff @(posedge clk) begin
    if (charTake && fieldDone) begin
      wordOut.value   <= nextAcc;
      wordOut.lineEnd <= charIn.lineEnd;
    end
  end

  // Load stream carries only asciized characters
  assert property (@(posedge clk) disable iff (!arstN)
    charValid |-> (charIn.ch >= asciiDirectLow) && (charIn.ch <= 7'o174));

endmodule

//--- src/cramRecordParser.sv
// C record parser
`timescale 1ns/1ns

module cramRecordParser import loadPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  wordBeatT wordIn,
  input  logic     wordValid,
  output logic     wordReady,
  output cramReqT  cramOut,
  output logic     cramValid,
  input  logic     cramReady,
  output logic     cksumErr
);

  typedef enum logic [1:0] {
    sWc,
    sAdr,
    sData,
    sCksum
  } parseStateT;

  parseStateT state;
  logic       wordTake;
  logic       lastSlot;
  logic       eofLine;
  logic [2:0] slot;
  loadWordT   left;
  loadWordT   sum;
  cramAdrT    curAdr;
  cramAdrT    contAdr;
  cramWordT   cw;

  // Stall the whole line while a finished CRAM word waits downstream
  assign wordReady = !cramValid || cramReady;
  assign wordTake  = wordValid && wordReady;
  assign lastSlot  = (slot == 3'(wordsPerCram - 1));

  ////////////////////////////////////////
  // Line state machine
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= sWc;
      slot      <= '0;
      left      <= '0;
      sum       <= '0;
      eofLine   <= 1'b0;
      curAdr    <= '0;
      contAdr   <= '0;
      cramValid <= 1'b0;
      cksumErr  <= 1'b0;
    end else begin
      // Drain the output slot unless refilled below
      if (cramReady) begin
        cramValid <= 1'b0;
      end
      if (wordTake) begin
        sum <= sum + wordIn.value;
        case (state)
          sWc: begin
            // Checksum restarts with the word count
            sum   <= wordIn.value;
            left  <= wordIn.value;
            state <= sAdr;
          end
          sAdr: begin
            slot <= '0;
            if (left == '0 && wordIn.value == '0) begin
              // End of file line
              eofLine <= 1'b1;
              contAdr <= '0;
              state   <= sCksum;
            end else begin
              eofLine <= 1'b0;
              // Zero address continues after the last word written
              curAdr  <= (wordIn.value == '0) ? contAdr : cramAdrT'(wordIn.value);
              state   <= (left == '0) ? sCksum : sData;
            end
          end
          sData: begin
            left <= left - loadWordT'(1);
            slot <= lastSlot ? '0 : slot + 3'd1;
            if (lastSlot) begin
              cramValid <= 1'b1;
              curAdr    <= curAdr + cramAdrT'(1);
              contAdr   <= curAdr + cramAdrT'(1);
            end
            if (left == loadWordT'(1)) begin
              state <= sCksum;
            end
          end
          default: begin
            // Negated checksum brings the line total to zero
            if (sum + wordIn.value != '0) begin
              cksumErr <= 1'b1;
            end
            if (eofLine) begin
              cramValid <= 1'b1;
            end
            eofLine <= 1'b0;
            state   <= sWc;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // CRAM word assembly
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wordTake && state == sData) begin
      case (slot)
        3'd0: cw[64:79] <= wordIn.value;
        3'd1: cw[48:63] <= wordIn.value;
        3'd2: cw[32:47] <= wordIn.value;
        3'd3: cw[16:31] <= wordIn.value;
        3'd4: cw[0:15]  <= wordIn.value;
        default: begin
          // Special field CALL and DISP from the low six bits
          cramOut.adr       <= curAdr;
          cramOut.word      <= {cw[0:79], wordIn.value[5:0]};
          cramOut.endOfLoad <= 1'b0;
        end
      endcase
    end else if (wordTake && state == sCksum && eofLine) begin
      cramOut.adr       <= '0;
      cramOut.word      <= '0;
      cramOut.endOfLoad <= 1'b1;
    end
  end

  // Decoder line ends must line up with the record structure
  assert property (@(posedge clk) disable iff (!arstN)
    (wordValid && wordIn.lineEnd) |-> (state == sCksum));

endmodule

//--- src/cramWriteSeq.sv
// CRAM diagnostic write sequencer
`timescale 1ns/1ns

module cramWriteSeq import loadPkg::*; import diagPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  cramReqT cramIn,
  input  logic    cramValid,
  output logic    cramReady,
  output diagReqT diagOut,
  output logic    diagValid,
  input  logic    diagReady,
  output logic    loadDone
);

  cramReqT  held;
  logic     full;
  logic     cramTake;
  logic     diagTake;
  cramStepT step;

  // Spread twenty CRAM bits over the five nibble slots
  function automatic ebusWordT packNibbles(cramWordT w, int base);
    ebusWordT p;
    p = '0;
    for (int k = 0; k < nibbleSlots; k++) begin
      // Lowest numbered CRAM bits go into the first slot
      p[nibbleSlotLsb[k] - 3 +: 4] = w[base + 4 * k +: 4];
    end
    return p;
  endfunction

  assign cramReady = !full;
  assign cramTake  = cramValid && cramReady;
  // End of load marker produces no bus cycle
  assign diagValid = full && !held.endOfLoad;
  assign diagTake  = diagValid && diagReady;

  ////////////////////////////////////////
  // Bus word for the current step
  ////////////////////////////////////////

  always_comb begin
    diagOut.data = '0;
    case (step)
      3'd0: begin
        diagOut.func      = diagCramAdrRh;
        diagOut.data[0:5] = held.adr[5:10];
      end
      3'd1: begin
        diagOut.func      = diagCramAdrLh;
        diagOut.data[1:5] = held.adr[0:4];
      end
      // Data writes run from the high bits down
      3'd2: begin
        diagOut.func = diagCramWrite60To79;
        diagOut.data = packNibbles(held.word, 60);
      end
      3'd3: begin
        diagOut.func = diagCramWrite40To59;
        diagOut.data = packNibbles(held.word, 40);
      end
      3'd4: begin
        diagOut.func = diagCramWrite20To39;
        diagOut.data = packNibbles(held.word, 20);
      end
      3'd5: begin
        diagOut.func = diagCramWrite00To19;
        diagOut.data = packNibbles(held.word, 0);
      end
      default: begin
        diagOut.func      = diagCramWrite80To85;
        diagOut.data[0:5] = held.word[80:85];
      end
    endcase
  end

  // Step control and load done pulse
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      full     <= 1'b0;
      step     <= '0;
      loadDone <= 1'b0;
    end else begin
      loadDone <= 1'b0;
      if (cramTake) begin
        full <= 1'b1;
        step <= '0;
      end else if (diagTake) begin
        if (step == cramLastStep) begin
          full <= 1'b0;
        end else begin
          step <= step + 3'd1;
        end
      end else if (full && held.endOfLoad && diagReady) begin
        // Driver idle again, so the last write has finished
        full     <= 1'b0;
        loadDone <= 1'b1;
      end
    end
  end

  // Held CRAM word
  always_ff @(posedge clk) begin
    if (cramTake) begin
      held <= cramIn;
    end
  end

endmodule

//--- src/diagBusDriver.sv
// Diagnostic bus write driver
`timescale 1ns/1ns

module diagBusDriver import diagPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  diagReqT  diagIn,
  input  logic     diagValid,
  output logic     diagReady,
  output diagFuncT diagFunc,
  output logic     diagStrobe,
  output ebusWordT ebusData,
  output logic     ebusDriving
);

  diagPhaseT phase;
  ebusWordT  dataQ;
  logic      reqTake;

  // Zero phase doubles as the trailing idle cycle
  assign diagReady = (phase == '0);
  assign reqTake   = diagValid && diagReady;
  // Data lines float back to zero once released
  assign ebusData  = ebusDriving ? dataQ : '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase       <= '0;
      diagStrobe  <= 1'b0;
      ebusDriving <= 1'b0;
    end else if (reqTake) begin
      phase       <= diagPhaseT'(1);
      diagStrobe  <= 1'b1;
      ebusDriving <= 1'b1;
    end else if (phase != '0) begin
      phase <= (phase == diagCycleLen - diagPhaseT'(1)) ? '0 : phase + diagPhaseT'(1);
      if (phase == strobeCycles) begin
        diagStrobe <= 1'b0;
      end
      if (phase == driveCycles) begin
        ebusDriving <= 1'b0;
      end
    end
  end

  // Function and data for the cycle
  always_ff @(posedge clk) begin
    if (reqTake) begin
      diagFunc <= diagIn.func;
      dataQ    <= diagIn.data;
    end
  end

  // Strobe must fall inside the data drive window
  assert property (@(posedge clk) disable iff (!arstN) diagStrobe |-> ebusDriving);

endmodule

//--- src/cramLoader.sv
// CRAM microcode loader top
`timescale 1ns/1ns

module cramLoader import loadPkg::*; import diagPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  charBeatT charIn,
  input  logic     charValid,
  output logic     charReady,
  output diagFuncT diagFunc,
  output logic     diagStrobe,
  output ebusWordT ebusData,
  output logic     ebusDriving,
  output logic     cksumErr,
  output logic     loadDone
);

  // Decoder to parser
  wordBeatT decWord;
  logic     decValid;
  logic     decReady;

  // Parser to sequencer
  cramReqT  parsedReq;
  logic     parsedValid;
  logic     parsedReady;

  // Sequencer to bus driver
  diagReqT  seqReq;
  logic     seqValid;
  logic     seqReady;

  ////////////////////////////////////////
  // Load pipeline
  ////////////////////////////////////////

  asciiDecoder i_asciiDecoder (
    .clk       (clk),
    .arstN     (arstN),
    .charIn    (charIn),
    .charValid (charValid),
    .charReady (charReady),
    .wordOut   (decWord),
    .wordValid (decValid),
    .wordReady (decReady)
  );

  cramRecordParser i_cramRecordParser (
    .clk       (clk),
    .arstN     (arstN),
    .wordIn    (decWord),
    .wordValid (decValid),
    .wordReady (decReady),
    .cramOut   (parsedReq),
    .cramValid (parsedValid),
    .cramReady (parsedReady),
    .cksumErr  (cksumErr)
  );

  cramWriteSeq i_cramWriteSeq (
    .clk       (clk),
    .arstN     (arstN),
    .cramIn    (parsedReq),
    .cramValid (parsedValid),
    .cramReady (parsedReady),
    .diagOut   (seqReq),
    .diagValid (seqValid),
    .diagReady (seqReady),
    .loadDone  (loadDone)
  );

  // Paces each write on the diagnostic bus
  diagBusDriver i_diagBusDriver (
    .clk         (clk),
    .arstN       (arstN),
    .diagIn      (seqReq),
    .diagValid   (seqValid),
    .diagReady   (seqReady),
    .diagFunc    (diagFunc),
    .diagStrobe  (diagStrobe),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

//--- verif/cramLoaderTb.sv
// CRAM loader testbench
`timescale 1ns/1ns

module cramLoaderTb import loadPkg::*; import diagPkg::*; ();

  // One row is one CRAM entry of a load line, adr is the address expected on the bus
  typedef struct packed {
    logic        newLine;
    logic        zeroAdr;
    logic        badCk;
    logic [10:0] adr;
    cramWordT    word;
  } rowT;

  localparam int numFixed = 8;
  // First EBUS bit of each data nibble slot
  localparam int slotStart [5] = '{8, 14, 20, 26, 32};
  // Data write functions by twenty bit group, 00-19 first
  localparam diagFuncT dataFunc [4] = '{diagCramWrite00To19, diagCramWrite20To39,
                                       diagCramWrite40To59, diagCramWrite60To79};

  // newLine, zeroAdr, badCk, address, CRAM word
  rowT fixedRows [numFixed] = '{
    '{1'b1, 1'b0, 1'b0, 11'd61,  {16'h0005, 16'h0fff, 16'habcd, 16'h003e, 16'h0f7f, 6'h2a}},
    '{1'b0, 1'b0, 1'b0, 11'd62,  {16'h1234, 16'h5678, 16'h9abc, 16'hdef0, 16'h0f80, 6'h3f}},
    '{1'b1, 1'b0, 1'b0, 11'h555, {86{1'b1}}},
    '{1'b1, 1'b1, 1'b0, 11'h556, {16'h0001, 16'h0040, 16'h1000, 16'h003d, 16'hfc00, 6'h01}},
    '{1'b0, 1'b0, 1'b0, 11'h557, {43{2'b10}}},
    '{1'b1, 1'b0, 1'b0, 11'h7ff, {16'h8001, 16'h7ffe, 16'h0041, 16'h0fc0, 16'h003f, 6'h20}},
    '{1'b1, 1'b0, 1'b1, 11'h2aa, 86'd0},
    '{1'b1, 1'b1, 1'b0, 11'h2ab, {43{2'b01}}}
  };

  logic        clk;
  logic        arstN;
  charBeatT    charIn;
  logic        charValid;
  logic        charReady;
  diagFuncT    diagFunc;
  logic        diagStrobe;
  ebusWordT    ebusData;
  logic        ebusDriving;
  logic        cksumErr;
  logic        loadDone;

  rowT         rows [$];
  charBeatT    charQ [$];
  diagReqT     expQ [$];
  string       expTag [$];
  logic [31:0] lcgState = 32'hbea3;
  logic        prevStrobe;
  logic        prevDriving;
  int          strobeRun;
  int          driveRun;
  logic        eofSent;
  int          doneCount;
  int          limitCycles;

  cramLoader i_cramLoader (
    .clk         (clk),
    .arstN       (arstN),
    .charIn      (charIn),
    .charValid   (charValid),
    .charReady   (charReady),
    .diagFunc    (diagFunc),
    .diagStrobe  (diagStrobe),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving),
    .cksumErr    (cksumErr),
    .loadDone    (loadDone)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic abortRun(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expV, input logic [63:0] actV);
    if (expV !== actV) begin
      $display("Fail %s expected %0h actual %0h", name, expV, actV);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic expectWrite(input diagFuncT f, input ebusWordT d, input string tag);
    expQ.push_back({f, d});
    expTag.push_back(tag);
  endtask

  // Seven bus writes of one CRAM word
  task automatic expectCram(input logic [10:0] adr, input cramWordT w, input string tag);
    ebusWordT d;
    d = '0;
    d[0:5] = adr[5:0];
    expectWrite(diagCramAdrRh, d, {tag, " adr rh"});
    d = '0;
    d[1:5] = adr[10:6];
    expectWrite(diagCramAdrLh, d, {tag, " adr lh"});
    // High group first, lowest CRAM bit of a group into the first slot
    for (int g = 3; g >= 0; g--) begin
      d = '0;
      for (int i = 0; i < 20; i++) begin
        d[slotStart[i / 4] + i % 4] = w[20 * g + i];
      end
      expectWrite(dataFunc[g], d, $sformatf("%s bits %0d-%0d", tag, 20 * g, 20 * g + 19));
    end
    d = '0;
    d[0:5] = w[80:85];
    expectWrite(diagCramWrite80To85, d, {tag, " bits 80-85"});
  endtask

  // Asciize one field, top digit first
  task automatic queueField(input loadWordT v, input logic last);
    int         n;
    logic [5:0] dg;
    charBeatT   b;
    n = (v > 16'd4095) ? 3 : (v > 16'd63) ? 2 : 1;
    for (int i = n - 1; i >= 0; i--) begin
      dg = 6'(v >> (6 * i));
      // 075-077 go as they are
      b.ch       = (dg >= 6'd61) ? {1'b0, dg} : {1'b0, dg} + 7'o100;
      b.fieldEnd = (i == 0) && !last;
      b.lineEnd  = (i == 0) && last;
      charQ.push_back(b);
    end
  endtask

  task automatic sendChars();
    logic [31:0] r;
    @(posedge clk);
    while (charQ.size() > 0) begin
      r = lcgNext();
      if (r[17:16] != 2'd0) begin
        charValid <= 1'b0;
        repeat (r[17:16]) @(posedge clk);
      end
      charIn    <= charQ.pop_front();
      charValid <= 1'b1;
      // Beat moves on the next rising edge with charReady high
      do begin
        @(negedge clk);
      end while (!charReady);
      @(posedge clk);
    end
    charValid <= 1'b0;
  endtask

  task automatic sendLine(input int first, input int count, input int lineNo);
    loadWordT w [$];
    loadWordT sum;
    loadWordT adrField;
    cramWordT cw;
    adrField = rows[first].zeroAdr ? 16'd0 : 16'(rows[first].adr);
    for (int k = first; k < first + count; k++) begin
      cw = rows[k].word;
      expectCram(rows[k].adr, cw, $sformatf("line %0d adr %0h", lineNo, rows[k].adr));
      w.push_back(cw[64:79]);
      w.push_back(cw[48:63]);
      w.push_back(cw[32:47]);
      w.push_back(cw[16:31]);
      w.push_back(cw[0:15]);
      w.push_back({10'd0, cw[80:85]});
    end
    sum = 16'(6 * count) + adrField;
    queueField(16'(6 * count), 1'b0);
    queueField(adrField, 1'b0);
    foreach (w[k]) begin
      sum = sum + w[k];
      queueField(w[k], 1'b0);
    end
    // Negated sum, one off on a corrupted line
    queueField(rows[first].badCk ? 16'd1 - sum : 16'd0 - sum, 1'b1);
    sendChars();
  endtask

  ////////////////////////////////////////
  // Bus monitor and watchdog
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (diagStrobe && !prevStrobe) begin
      check("drive at strobe rise", 64'd1, 64'(ebusDriving));
      if (expQ.size() == 0) begin
        abortRun("A bus write cycle appeared with no write expected");
      end else begin
        check({expTag[0], " func"}, 64'(expQ[0].func), 64'(diagFunc));
        check({expTag[0], " data"}, 64'(expQ[0].data), 64'(ebusData));
        void'(expQ.pop_front());
        void'(expTag.pop_front());
      end
    end
    // Strobe lasts three cycles and the drive window four
    if (diagStrobe) begin
      strobeRun++;
    end else if (prevStrobe) begin
      check("strobe cycles", 64'd3, 64'(strobeRun));
      strobeRun = 0;
    end
    if (ebusDriving) begin
      driveRun++;
    end else begin
      if (prevDriving) begin
        check("drive cycles", 64'd4, 64'(driveRun));
        driveRun = 0;
      end
      check("released ebusData", 64'd0, 64'(ebusData));
    end
    if (loadDone) begin
      doneCount++;
      if (!eofSent || expQ.size() != 0) begin
        abortRun("loadDone pulsed before all expected bus writes were seen");
      end else begin
        check("bus idle at loadDone", 64'd0, 64'(ebusDriving));
      end
    end
    prevStrobe  = diagStrobe;
    prevDriving = ebusDriving;
  end

  initial begin
    while (limitCycles == 0) @(posedge clk);
    repeat (limitCycles) @(posedge clk);
    abortRun($sformatf("Timeout, the load did not complete in %0d cycles", limitCycles));
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int   first;
    int   count;
    int   lineNo;
    rowT  r;
    arstN       = 1'b0;
    charValid   = 1'b0;
    charIn      = '0;
    prevStrobe  = 1'b0;
    prevDriving = 1'b0;
    eofSent     = 1'b0;
    foreach (fixedRows[k]) begin
      rows.push_back(fixedRows[k]);
    end
    // Walking one over all 86 bits, four words per line, continued addresses
    for (int b = 0; b < 86; b++) begin
      r         = '0;
      r.newLine = (b % 4 == 0);
      r.zeroAdr = (b != 0);
      r.adr     = 11'h700 + 11'(b);
      r.word[b] = 1'b1;
      rows.push_back(r);
    end
    // At most three characters per field, nine fields per CRAM word
    limitCycles = 40 * (rows.size() + 1) + 20 * 3 * (9 * rows.size() + 3) + 200;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    check("reset charReady", 64'd1, 64'(charReady));
    check("reset diagStrobe", 64'd0, 64'(diagStrobe));
    check("reset ebusDriving", 64'd0, 64'(ebusDriving));
    check("reset cksumErr", 64'd0, 64'(cksumErr));
    check("reset loadDone", 64'd0, 64'(loadDone));
    first  = 0;
    lineNo = 0;
    while (first < rows.size()) begin
      count = 1;
      while (first + count < rows.size() && !rows[first + count].newLine) begin
        count++;
      end
      if (rows[first].badCk) begin
        // Earlier lines fully written, so their checksums are already judged
        while (expQ.size() != 0) @(negedge clk);
        check("cksumErr before bad line", 64'd0, 64'(cksumErr));
      end
      sendLine(first, count, lineNo);
      first += count;
      lineNo++;
    end
    // End of file line, WC and ADR zero
    eofSent = 1'b1;
    queueField(16'd0, 1'b0);
    queueField(16'd0, 1'b0);
    queueField(16'd0, 1'b1);
    sendChars();
    while (doneCount == 0) @(negedge clk);
    repeat (50) @(negedge clk);
    check("loadDone pulse count", 64'd1, 64'(doneCount));
    check("bus writes left", 64'd0, 64'(expQ.size()));
    check("cksumErr after load", 64'd1, 64'(cksumErr));
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- build.f
src/diagPkg.sv
src/loadPkg.sv
src/asciiDecoder.sv
src/cramRecordParser.sv
src/cramWriteSeq.sv
src/diagBusDriver.sv
src/cramLoader.sv
verif/cramLoaderTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the CRAM loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module cramLoaderTb -o cramLoaderSim

out=$(./obj_dir/cramLoaderSim 2>&1) || true
echo "$out"
grep -q "ALL CHECKS PASSED" <<< "$out"
